//--- compile.f
source/fedp_pkg.sv
source/fedp_classify.sv
source/fedp_prod_exp.sv
source/fedp_special.sv
source/fedp_exp_align.sv
source/fedp_exp_stage.sv
bench/fedp_exp_stage_sva.sv
bench/fedp_exp_stage_tb.sv

//--- Makefile
# Verilator build and run of the exponent stage testbench

VERILATOR ?= verilator
TOP       ?= fedp_exp_stage_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# Pass or fail is read from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/fedp_exp_stage_tb.sv
`timescale 1ns/10ps

module fedp_exp_stage_tb import fedp_pkg::*; ();

    localparam int          BEATS        = 2000;
    localparam int          CLK_PERIOD   = 8;
    localparam int          RESET_CYCLES = 16;
    localparam logic [31:0] SEED         = 32'd73924;

    // Field layout of one packed element
    typedef struct packed {
        logic [7:0] ew;
        logic [7:0] mw;
        logic [7:0] mk;
    } fmt_info_t;

    typedef struct packed {
        logic       sign;
        logic       zero;
        logic       sub;
        logic       inf;
        logic       nan;
        logic [7:0] e;
    } elem_t;

    logic          clk;
    logic          rst_n;
    logic          in_valid;
    fmt_t          fmt;
    mask_t         vld_mask;
    word_t [N-1:0] a_row;
    word_t [N-1:0] b_col;
    word_t         c_val;
    logic          out_valid;
    exp_out_t      result;

    logic [31:0]   lfsr;
    exp_out_t      exp_q[$];
    exp_out_t      held;
    logic          prev_valid;
    int            sent;
    int            checked;
    int            errors;

    fedp_exp_stage fedp_exp_stage_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .fmt       (fmt),
        .vld_mask  (vld_mask),
        .a_row     (a_row),
        .b_col     (b_col),
        .c_val     (c_val),
        .out_valid (out_valid),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------
    // Random source
    // ------------------------------------------------------------
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw(input int nbits, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // Exponent width, mantissa field width, significant mantissa bits
    function automatic fmt_info_t fmt_info(input fmt_t f);
        case (f)
            FMT_TF32: return '{8'd8, 8'd23, 8'd10};
            FMT_FP16: return '{8'd5, 8'd10, 8'd10};
            FMT_BF16: return '{8'd8, 8'd7, 8'd7};
            FMT_FP8:  return '{8'd4, 8'd3, 8'd3};
            FMT_BF8:  return '{8'd5, 8'd2, 8'd2};
            default:  return '0;
        endcase
    endfunction

    // Exponent and mantissa lean toward empty and all-ones fields
    task automatic rand_elem(input int ew, input int mw, output logic [31:0] v);
        logic [31:0] sel, s, e, m;
        draw(1, s);
        draw(2, sel);
        draw(ew, e);
        if (sel[1:0] == 2'd0) e = '0;
        if (sel[1:0] == 2'd1) e = (32'd1 << ew) - 32'd1;
        draw(2, sel);
        draw(mw, m);
        if (sel[1:0] == 2'd0) m = '0;
        if (sel[1:0] == 2'd1) m = (32'd1 << mw) - 32'd1;
        v = (s << (ew + mw)) | (e << mw) | m;
    endtask

    task automatic rand_row(input fmt_t f, output word_t [N-1:0] row);
        fmt_info_t   fi;
        int          width;
        logic [31:0] v;
        fi    = fmt_info(f);
        width = fi.ew + fi.mw + 1;
        for (int w = 0; w < N; w++) begin
            row[w] = '0;
            if (fi.ew == 0) begin
                draw(32, v);
                row[w] = v;
            end else begin
                for (int p = 0; p < 32; p += width) begin
                    rand_elem(fi.ew, fi.mw, v);
                    row[w] = row[w] | (v << p);
                end
            end
        end
    endtask

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    function automatic elem_t decode(input fmt_t f, input logic [63:0] bits, input mask_t m,
                                     input int k);
        fmt_info_t   fi;
        int          width;
        logic [31:0] raw, man, emax;
        elem_t       el;
        fi      = fmt_info(f);
        el      = '0;
        el.zero = 1'b1;
        if (fi.ew == 0) return el;
        width = fi.ew + fi.mw + 1;
        // Mask bit 4k for wide slots and 2k for 8-bit slots
        if (k >= 64 / width || !m[(width == 8) ? k * 2 : k * 4]) return el;
        raw     = 32'(bits >> (k * width));
        man     = (raw & ((32'd1 << fi.mw) - 32'd1)) >> (fi.mw - fi.mk);
        emax    = (32'd1 << fi.ew) - 32'd1;
        el.e    = 8'((raw >> fi.mw) & emax);
        el.sign = raw[width - 1];
        el.zero = (el.e == 8'd0) && (man == 0);
        el.sub  = (el.e == 8'd0) && (man != 0);
        if (f == FMT_FP8) begin
            el.nan = (el.e == emax[7:0]) && (man == 32'd7);
        end else begin
            el.inf = (el.e == emax[7:0]) && (man == 0);
            el.nan = (el.e == emax[7:0]) && (man != 0);
        end
        return el;
    endfunction

    function automatic exp_out_t model(input fmt_t f, input mask_t m, input word_t [N-1:0] a,
                                       input word_t [N-1:0] b, input word_t c);
        fmt_info_t fi;
        elem_t     ea, eb;
        int        nelem, t, bias, s, mx;
        int        raw[TCK+1];
        logic      live[TCK+1];
        logic      found, pn, pi, pos, neg, anynan;
        exp_out_t  r;
        fi     = fmt_info(f);
        r      = '0;
        nelem  = (fi.ew == 0) ? 0 : 64 / (fi.ew + fi.mw + 1);
        bias   = (nelem == 0) ? 0 :
                 127 - 2 * ((1 << (fi.ew - 1)) - 1) + ((nelem == 8) ? 2 : 1) - W;
        pos    = 1'b0;
        neg    = 1'b0;
        anynan = 1'b0;
        for (int i = 0; i <= TCK; i++) begin
            raw[i]  = 0;
            live[i] = 1'b0;
        end
        for (int k = 0; k < nelem; k++) begin
            ea     = decode(f, a, m, k);
            eb     = decode(f, b, m, k);
            t      = k * TCK / nelem;
            pn     = ea.nan | eb.nan | (ea.inf & eb.zero) | (eb.inf & ea.zero);
            pi     = (ea.inf | eb.inf) & ~pn;
            anynan = anynan | pn;
            pos    = pos | (pi & ~(ea.sign ^ eb.sign));
            neg    = neg | (pi & (ea.sign ^ eb.sign));
            if (!ea.zero && !eb.zero) begin
                s = bias + (ea.sub ? 1 : int'(ea.e)) + (eb.sub ? 1 : int'(eb.e));
                // 8-bit pairs keep the larger sub-product
                if (!live[t] || s > raw[t]) begin
                    raw[t] = s;
                end
                live[t] = 1'b1;
            end
        end
        if (c[30:0] != 31'd0) begin
            raw[TCK]  = ((c[30:23] == 8'd0) ? 1 : int'(c[30:23])) - (W - 1);
            live[TCK] = 1'b1;
        end
        if (&c[30:23]) begin
            anynan = anynan | (c[22:0] != 23'd0);
            pos    = pos | ((c[22:0] == 23'd0) & ~c[31]);
            neg    = neg | ((c[22:0] == 23'd0) & c[31]);
        end
        found = 1'b0;
        mx    = 0;
        for (int i = 0; i <= TCK; i++) begin
            if (live[i] && (!found || raw[i] > mx)) begin
                mx    = raw[i];
                found = 1'b1;
            end
        end
        r.max_exp = exp_t'(mx);
        for (int i = 0; i <= TCK; i++) begin
            r.term_zero[i] = ~live[i];
            if (live[i]) begin
                r.shift[i] = shift_t'((mx - raw[i] > 127) ? 127 : mx - raw[i]);
            end
        end
        r.is_nan   = anynan | (pos & neg);
        r.is_inf   = ~r.is_nan & (pos | neg);
        r.inf_sign = ~r.is_nan & neg;
        return r;
    endfunction

    // ------------------------------------------------------------
    // Stimulus and checks
    // ------------------------------------------------------------
    task automatic drive_beat();
        logic [31:0] r, v;
        draw(4, r);
        if (r[3:0] == 4'd15) begin
            draw(3, r);
            fmt = fmt_t'(r[2:0]);
        end else begin
            fmt = fmt_t'(32'd1 + r % 5);
        end
        draw(3, r);
        draw(16, v);
        vld_mask = v[15:0];
        if (r[2:0] == 3'd0) vld_mask = '0;
        if (r[2:0] >= 3'd5) vld_mask = '1;
        rand_row(fmt, a_row);
        rand_row(fmt, b_col);
        rand_elem(8, 23, v);
        c_val = v;
        draw(4, r);
        if (r[3:0] == 4'd0) begin
            a_row = '0;
            b_col = '0;
            c_val = '0;
        end
        draw(2, r);
        in_valid   = (r[1:0] != 2'd0);
        prev_valid = in_valid;
        if (in_valid) begin
            exp_q.push_back(model(fmt, vld_mask, a_row, b_col, c_val));
            sent++;
        end
    endtask

    // Outputs are stable at the falling edge
    task automatic check_outputs();
        if (out_valid !== prev_valid) begin
            errors++;
            $display("ERR %0t: out_valid %b, expected %b", $time, out_valid, prev_valid);
        end
        if (prev_valid) begin
            held = exp_q.pop_front();
            checked++;
        end
        if (result.max_exp !== held.max_exp || result.shift !== held.shift ||
            result.term_zero !== held.term_zero) begin
            errors++;
            $display("ERR %0t: max_exp %0d shift %h zero %b, expected %0d %h %b", $time,
                     $signed(result.max_exp), result.shift, result.term_zero,
                     $signed(held.max_exp), held.shift, held.term_zero);
        end
        if ({result.is_nan, result.is_inf, result.inf_sign} !==
            {held.is_nan, held.is_inf, held.inf_sign}) begin
            errors++;
            $display("ERR %0t: nan/inf/sign %b%b%b, expected %b%b%b", $time,
                     result.is_nan, result.is_inf, result.inf_sign,
                     held.is_nan, held.is_inf, held.inf_sign);
        end
    endtask

    initial begin
        lfsr       = SEED;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        fmt        = FMT_FP16;
        vld_mask   = '0;
        a_row      = '0;
        b_col      = '0;
        c_val      = '0;
        prev_valid = 1'b0;
        held       = '0;
        sent       = 0;
        checked    = 0;
        errors     = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        if (out_valid !== 1'b0 || result !== '0) begin
            errors++;
            $display("ERR %0t: outputs not cleared by reset", $time);
        end
        rst_n = 1'b1;
        while (sent < BEATS) begin
            @(negedge clk);
            check_outputs();
            drive_beat();
        end
        @(negedge clk);
        check_outputs();
        in_valid   = 1'b0;
        prev_valid = 1'b0;
        // Result must hold once the strobe drops
        @(negedge clk);
        check_outputs();
        $display("Errors: %0d, results checked: %0d of %0d", errors, checked, BEATS);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Each beat needs at most two cycles on average with the gaps
    initial begin
        #(BEATS * 2 * CLK_PERIOD + (RESET_CYCLES + 8) * CLK_PERIOD);
        $display("Timeout: the run did not finish in the expected time");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- bench/fedp_exp_stage_sva.sv
`timescale 1ns/10ps

module fedp_exp_stage_sva import fedp_pkg::*; (
    input logic         clk,
    input logic         rst_n,
    input logic         out_valid,
    input exp_out_t     result,
    input exp_t [TCK:0] raw_exp
);

    // Output strobe stays low while reset is held
    a_reset_idle: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else $error("out_valid high during reset");

    a_special_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(result.is_nan && result.is_inf))
        else $error("is_nan and is_inf both set");

    // ------------------------------------------------------------
    // Largest live term needs no alignment
    // ------------------------------------------------------------
    for (genvar t = 0; t <= TCK; t++) begin : g_shift
        a_max_no_shift: assert property (@(posedge clk) disable iff (!rst_n)
            out_valid && !result.term_zero[t] && ($past(raw_exp[t]) == result.max_exp)
            |-> (result.shift[t] == '0))
            else $error("term %0d at max_exp has shift %0d", t, result.shift[t]);
    end

endmodule

bind fedp_exp_stage fedp_exp_stage_sva fedp_exp_stage_sva_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .out_valid (out_valid),
    .result    (result),
    .raw_exp   (raw_exp)
);

//--- source/fedp_exp_stage.sv
`timescale 1ns/10ps

module fedp_exp_stage import fedp_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          in_valid,
    input  fmt_t          fmt,
    input  mask_t         vld_mask,
    input  word_t [N-1:0] a_row,
    input  word_t [N-1:0] b_col,
    input  word_t         c_val,
    output logic          out_valid,
    output exp_out_t      result
);

    fedp_class_t [CLS_ELEMS-1:0] cls_a, cls_b;
    fedp_class_t                 cls_c;
    exp_t [TCK:0]                raw_exp;
    logic [TCK:0]                term_zero;
    logic                        is_nan, is_inf, inf_sign;

    // ------------------------------------------------------------
    // Combinational front end
    // ------------------------------------------------------------
    fedp_classify fedp_classify_i (
        .fmt      (fmt),
        .vld_mask (vld_mask),
        .a_row    (a_row),
        .b_col    (b_col),
        .c_val    (c_val),
        .cls_a    (cls_a),
        .cls_b    (cls_b),
        .cls_c    (cls_c)
    );

    fedp_prod_exp fedp_prod_exp_i (
        .fmt       (fmt),
        .a_row     (a_row),
        .b_col     (b_col),
        .c_val     (c_val),
        .cls_a     (cls_a),
        .cls_b     (cls_b),
        .cls_c     (cls_c),
        .raw_exp   (raw_exp),
        .term_zero (term_zero)
    );

    fedp_special fedp_special_i (
        .fmt      (fmt),
        .cls_a    (cls_a),
        .cls_b    (cls_b),
        .cls_c    (cls_c),
        .is_nan   (is_nan),
        .is_inf   (is_inf),
        .inf_sign (inf_sign)
    );

    // Single register stage
    fedp_exp_align fedp_exp_align_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .raw_exp   (raw_exp),
        .term_zero (term_zero),
        .is_nan    (is_nan),
        .is_inf    (is_inf),
        .inf_sign  (inf_sign),
        .out_valid (out_valid),
        .result    (result)
    );

endmodule

//--- source/fedp_exp_align.sv
`timescale 1ns/10ps

module fedp_exp_align import fedp_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         in_valid,
    input  exp_t [TCK:0] raw_exp,
    input  logic [TCK:0] term_zero,
    input  logic         is_nan,
    input  logic         is_inf,
    input  logic         inf_sign,
    output logic         out_valid,
    output exp_out_t     result
);

    exp_t                  max_exp;
    logic                  found;
    logic [TCK:0][EXP_W:0] diff;
    exp_out_t              result_d;

    // Largest exponent over live terms, 0 if none
    always_comb begin
        found   = 1'b0;
        max_exp = '0;
        for (int t = 0; t <= TCK; t++) begin
            if (!term_zero[t] && (!found || $signed(raw_exp[t]) > $signed(max_exp))) begin
                max_exp = raw_exp[t];
                found   = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Alignment shifts
    // ------------------------------------------------------------
    always_comb begin
        result_d           = '0;
        result_d.max_exp   = max_exp;
        result_d.term_zero = term_zero;
        result_d.is_nan    = is_nan;
        result_d.is_inf    = is_inf;
        result_d.inf_sign  = inf_sign;
        for (int t = 0; t <= TCK; t++) begin
            // One extra bit, never negative for a live term
            diff[t] = {max_exp[EXP_W-1], max_exp} - {raw_exp[t][EXP_W-1], raw_exp[t]};
            if (term_zero[t]) begin
                result_d.shift[t] = '0;
            end else if (|diff[t][EXP_W:$bits(shift_t)]) begin
                result_d.shift[t] = SHIFT_MAX;
            end else begin
                result_d.shift[t] = diff[t][$bits(shift_t)-1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                result <= result_d;
            end
        end
    end

endmodule

//--- source/fedp_special.sv
`timescale 1ns/10ps

module fedp_special import fedp_pkg::*; (
    input  fmt_t                        fmt,
    input  fedp_class_t [CLS_ELEMS-1:0] cls_a,
    input  fedp_class_t [CLS_ELEMS-1:0] cls_b,
    input  fedp_class_t                 cls_c,
    output logic                        is_nan,
    output logic                        is_inf,
    output logic                        inf_sign
);

    logic [4:0] n_slots;
    logic       any_nan, pos_inf, neg_inf;
    logic       p_nan, p_inf, p_sign;

    // Active element pairs per format
    always_comb begin
        case (fmt)
            FMT_TF32:           n_slots = 5'(N);
            FMT_FP16, FMT_BF16: n_slots = 5'(2 * N);
            FMT_FP8, FMT_BF8:   n_slots = 5'(4 * N);
            default:            n_slots = '0;
        endcase
    end

    always_comb begin
        any_nan = cls_c.is_nan;
        pos_inf = cls_c.is_inf & ~cls_c.sign;
        neg_inf = cls_c.is_inf & cls_c.sign;
        for (int k = 0; k < CLS_ELEMS; k++) begin
            // inf * 0 is invalid
            p_nan  = cls_a[k].is_nan | cls_b[k].is_nan |
                     (cls_a[k].is_inf & cls_b[k].is_zero) |
                     (cls_b[k].is_inf & cls_a[k].is_zero);
            p_inf  = (cls_a[k].is_inf | cls_b[k].is_inf) & ~p_nan;
            p_sign = cls_a[k].sign ^ cls_b[k].sign;
            if (k < n_slots) begin
                any_nan = any_nan | p_nan;
                pos_inf = pos_inf | (p_inf & ~p_sign);
                neg_inf = neg_inf | (p_inf & p_sign);
            end
        end
    end

    // Opposing infinities cancel into NaN
    assign is_nan   = any_nan | (pos_inf & neg_inf);
    assign is_inf   = ~is_nan & (pos_inf | neg_inf);
    assign inf_sign = ~is_nan & neg_inf;

endmodule

//--- source/fedp_prod_exp.sv
`timescale 1ns/10ps

module fedp_prod_exp import fedp_pkg::*; (
    input  fmt_t                        fmt,
    input  word_t [N-1:0]               a_row,
    input  word_t [N-1:0]               b_col,
    input  word_t                       c_val,
    input  fedp_class_t [CLS_ELEMS-1:0] cls_a,
    input  fedp_class_t [CLS_ELEMS-1:0] cls_b,
    input  fedp_class_t                 cls_c,
    output exp_t [TCK:0]                raw_exp,
    output logic [TCK:0]                term_zero
);

    logic is_f8;

    // Subnormals enter the sum with exponent 1
    function automatic logic [7:0] eff_exp(input logic is_sub, input logic [7:0] e);
        return is_sub ? 8'd1 : e;
    endfunction

    function automatic exp_t widen(input logic [7:0] e);
        return exp_t'({{(EXP_W - 8){1'b0}}, e});
    endfunction

    assign is_f8 = (fmt == FMT_FP8) || (fmt == FMT_BF8);

    // ------------------------------------------------------------
    // Product terms
    // ------------------------------------------------------------
    for (genvar i = 0; i < TCK; i++) begin : g_term
        localparam int WD  = i / 2;
        localparam int OFF = (i % 2) * 16;

        logic [7:0]      ea, eb;
        exp_t            bias;
        logic            zero;
        logic [1:0][7:0] ea8, eb8;
        exp_t            bias8;
        logic [1:0]      zero8;
        exp_t            sum_wide, sum8_lo, sum8_hi, diff8;
        logic            lo_larger;

        // Operand select for the shared adder and the 8-bit pair
        always_comb begin
            ea    = '0;
            eb    = '0;
            bias  = '0;
            zero  = 1'b1;
            ea8   = '0;
            eb8   = '0;
            bias8 = '0;
            zero8 = 2'b11;
            case (fmt)
                FMT_TF32: begin
                    // Odd lanes stay empty, one TF32 per word
                    if (OFF == 0) begin
                        ea   = eff_exp(cls_a[WD].is_sub, a_row[WD][30:23]);
                        eb   = eff_exp(cls_b[WD].is_sub, b_col[WD][30:23]);
                        zero = cls_a[WD].is_zero | cls_b[WD].is_zero;
                        bias = BIAS_TF32;
                    end
                end
                FMT_FP16: begin
                    ea   = eff_exp(cls_a[i].is_sub, {3'd0, a_row[WD][OFF + 14 -: 5]});
                    eb   = eff_exp(cls_b[i].is_sub, {3'd0, b_col[WD][OFF + 14 -: 5]});
                    zero = cls_a[i].is_zero | cls_b[i].is_zero;
                    bias = BIAS_FP16;
                end
                FMT_BF16: begin
                    ea   = eff_exp(cls_a[i].is_sub, a_row[WD][OFF + 14 -: 8]);
                    eb   = eff_exp(cls_b[i].is_sub, b_col[WD][OFF + 14 -: 8]);
                    zero = cls_a[i].is_zero | cls_b[i].is_zero;
                    bias = BIAS_BF16;
                end
                FMT_FP8, FMT_BF8: begin
                    for (int j = 0; j < 2; j++) begin
                        if (fmt == FMT_FP8) begin
                            ea8[j] = {4'd0, a_row[WD][OFF + j * 8 + 6 -: 4]};
                            eb8[j] = {4'd0, b_col[WD][OFF + j * 8 + 6 -: 4]};
                        end else begin
                            ea8[j] = {3'd0, a_row[WD][OFF + j * 8 + 6 -: 5]};
                            eb8[j] = {3'd0, b_col[WD][OFF + j * 8 + 6 -: 5]};
                        end
                        ea8[j]   = eff_exp(cls_a[2 * i + j].is_sub, ea8[j]);
                        eb8[j]   = eff_exp(cls_b[2 * i + j].is_sub, eb8[j]);
                        zero8[j] = cls_a[2 * i + j].is_zero | cls_b[2 * i + j].is_zero;
                    end
                    bias8 = (fmt == FMT_FP8) ? BIAS_FP8 : BIAS_BF8;
                end
                default: ;
            endcase
        end

        assign sum_wide = bias + widen(ea) + widen(eb);
        assign sum8_lo  = bias8 + widen(ea8[0]) + widen(eb8[0]);
        assign sum8_hi  = bias8 + widen(ea8[1]) + widen(eb8[1]);
        assign diff8    = sum8_hi - sum8_lo;

        // Low member wins when it is larger or the high one is zero
        assign lo_larger = zero8[1] | (~zero8[0] & diff8[EXP_W-1]);

        assign term_zero[i] = is_f8 ? &zero8 : zero;
        assign raw_exp[i]   = term_zero[i] ? '0 :
                              (is_f8 ? (lo_larger ? sum8_lo : sum8_hi) : sum_wide);
    end

    // C term sits W-1 below its FP32 exponent
    assign term_zero[TCK] = cls_c.is_zero;
    assign raw_exp[TCK]   = cls_c.is_zero ? '0 :
                            widen(eff_exp(cls_c.is_sub, c_val[30:23])) - exp_t'(W - 1);

endmodule

//--- source/fedp_classify.sv
`timescale 1ns/10ps

module fedp_classify import fedp_pkg::*; (
    input  fmt_t                        fmt,
    input  mask_t                       vld_mask,
    input  word_t [N-1:0]               a_row,
    input  word_t [N-1:0]               b_col,
    input  word_t                       c_val,
    output fedp_class_t [CLS_ELEMS-1:0] cls_a,
    output fedp_class_t [CLS_ELEMS-1:0] cls_b,
    output fedp_class_t                 cls_c
);

    // Class flags from decoded fields
    function automatic fedp_class_t make_class(
        input logic valid,
        input logic sign,
        input logic exp_zero,
        input logic man_zero,
        input logic inf,
        input logic nan
    );
        fedp_class_t c;
        c = CLS_ZERO;
        if (valid) begin
            c.sign    = sign;
            c.is_zero = exp_zero & man_zero;
            c.is_sub  = exp_zero & ~man_zero;
            c.is_inf  = inf;
            c.is_nan  = nan;
        end
        return c;
    endfunction

    // Slot k of a packed operand under format f
    function automatic fedp_class_t classify_slot(
        input fmt_t          f,
        input word_t [N-1:0] row,
        input mask_t         m,
        input int            k
    );
        word_t       w;
        logic [15:0] h;
        logic [7:0]  q;
        fedp_class_t c;
        c = CLS_ZERO;
        w = row[k % N];
        h = row[(k / 2) % N][(k % 2) * 16 +: 16];
        q = row[(k / 4) % N][(k % 4) * 8 +: 8];
        case (f)
            FMT_TF32: begin
                // Mantissa is the top 10 bits of the FP32 field
                if (k < N) begin
                    c = make_class(m[k * 4], w[31], w[30:23] == '0, w[22:13] == '0,
                                   &w[30:23] & (w[22:13] == '0),
                                   &w[30:23] & (w[22:13] != '0));
                end
            end
            FMT_FP16: begin
                if (k < 2 * N) begin
                    c = make_class(m[k * 4], h[15], h[14:10] == '0, h[9:0] == '0,
                                   &h[14:10] & (h[9:0] == '0),
                                   &h[14:10] & (h[9:0] != '0));
                end
            end
            FMT_BF16: begin
                if (k < 2 * N) begin
                    c = make_class(m[k * 4], h[15], h[14:7] == '0, h[6:0] == '0,
                                   &h[14:7] & (h[6:0] == '0),
                                   &h[14:7] & (h[6:0] != '0));
                end
            end
            FMT_FP8: begin
                // E4M3 has no infinity
                // Only S.1111.111 is NaN
                if (k < 4 * N) begin
                    c = make_class(m[k * 2], q[7], q[6:3] == '0, q[2:0] == '0,
                                   1'b0, &q[6:0]);
                end
            end
            FMT_BF8: begin
                if (k < 4 * N) begin
                    c = make_class(m[k * 2], q[7], q[6:2] == '0, q[1:0] == '0,
                                   &q[6:2] & (q[1:0] == '0),
                                   &q[6:2] & (q[1:0] != '0));
                end
            end
            default: ;
        endcase
        return c;
    endfunction

    always_comb begin
        for (int k = 0; k < CLS_ELEMS; k++) begin
            cls_a[k] = classify_slot(fmt, a_row, vld_mask, k);
            cls_b[k] = classify_slot(fmt, b_col, vld_mask, k);
        end
    end

    // Accumulator is always FP32
    assign cls_c = make_class(1'b1, c_val[31], c_val[30:23] == '0, c_val[22:0] == '0,
                              &c_val[30:23] & (c_val[22:0] == '0),
                              &c_val[30:23] & (c_val[22:0] != '0));

endmodule

//--- source/fedp_pkg.sv
package fedp_pkg;

    // ------------------------------------------------------------
    // Datapath sizes
    // ------------------------------------------------------------
    localparam int N         = 2;
    localparam int TCK       = 4;
    localparam int W         = 25;
    localparam int EXP_W     = 10;
    localparam int CLS_ELEMS = 16;

    typedef logic [2:0]              fmt_t;
    typedef logic [31:0]             word_t;
    typedef logic [CLS_ELEMS-1:0]    mask_t;
    typedef logic signed [EXP_W-1:0] exp_t;
    typedef logic [6:0]              shift_t;

    // Format codes, all other codes are invalid
    localparam fmt_t FMT_FP16 = 3'd1;
    localparam fmt_t FMT_BF16 = 3'd2;
    localparam fmt_t FMT_FP8  = 3'd3;
    localparam fmt_t FMT_BF8  = 3'd4;
    localparam fmt_t FMT_TF32 = 3'd5;

    // Source format exponent biases
    localparam int F32_BIAS    = 127;
    localparam int B_TF32      = 127;
    localparam int B_FP16      = 15;
    localparam int B_BF16      = 127;
    localparam int B_FP8       = 7;
    localparam int B_BF8       = 15;
    localparam int ALIGN_SHIFT = 1;

    // Rebias a product sum into the FP32 accumulation window
    localparam exp_t BIAS_TF32 = exp_t'(F32_BIAS - 2 * B_TF32 + ALIGN_SHIFT - W);
    localparam exp_t BIAS_FP16 = exp_t'(F32_BIAS - 2 * B_FP16 + ALIGN_SHIFT - W);
    localparam exp_t BIAS_BF16 = exp_t'(F32_BIAS - 2 * B_BF16 + ALIGN_SHIFT - W);
    localparam exp_t BIAS_FP8  = exp_t'(F32_BIAS - 2 * B_FP8 + 2 * ALIGN_SHIFT - W);
    localparam exp_t BIAS_BF8  = exp_t'(F32_BIAS - 2 * B_BF8 + 2 * ALIGN_SHIFT - W);

    localparam shift_t SHIFT_MAX = 7'd127;

    // ------------------------------------------------------------
    // Element class and stage result
    // ------------------------------------------------------------
    typedef struct packed {
        logic sign;
        logic is_zero;
        logic is_sub;
        logic is_inf;
        logic is_nan;
    } fedp_class_t;

    // Unused or masked slot
    localparam fedp_class_t CLS_ZERO = '{sign: 1'b0, is_zero: 1'b1, is_sub: 1'b0,
                                         is_inf: 1'b0, is_nan: 1'b0};

    typedef struct packed {
        exp_t           max_exp;
        shift_t [TCK:0] shift;
        logic [TCK:0]   term_zero;
        logic           is_nan;
        logic           is_inf;
        logic           inf_sign;
    } exp_out_t;

endpackage
